// File: src/stream_pkg.sv
////////////////////
// Data-path types for the sample stream
// Sample word and framed egress beat
////////////////////

`default_nettype none

package stream_pkg;

  ////////////////////
  // Sample word
  ////////////////////

  typedef logic [15:0] sample_t;  // One ingress sample

  ////////////////////
  // Egress beat
  ////////////////////

  // One word of a burst with its frame markers
  typedef struct packed {
    logic    sof;   // First beat of a burst
    logic    eof;   // Last beat of a burst
    sample_t data;  // Payload
  } beat_t;         // 18 bits

endpackage

`default_nettype wire

// File: src/ctrl_pkg.sv
////////////////////
// Control types for the burst packer
// Widths, config and status structs, burst FSM states
////////////////////

`default_nettype none

package ctrl_pkg;

  typedef logic [8:0]  level_t;    // Fill level or threshold, up to 256
  typedef logic [11:0] timeout_t;  // Flush timeout in clock cycles

  ////////////////////
  // Configuration
  ////////////////////

  typedef struct packed {
    level_t   burst_len;          // Words per full burst
    level_t   almost_full_level;  // Threshold for almost_full
    timeout_t flush_timeout;      // Idle cycles before a partial burst
  } cfg_t;                        // 30 bits

  ////////////////////
  // Status
  ////////////////////

  typedef struct packed {
    level_t fill_level;      // Words held now
    level_t max_fill_level;  // Highest level seen since reset
    logic   almost_full;     // Level at or above threshold
    logic   full;            // No room left
    logic   overflow;        // Sticky, a sample was dropped
  } status_t;                // 21 bits

  // Burst controller states
  typedef enum logic {
    IDLE,   // Waiting for a trigger
    BURST   // Draining a burst
  } burst_state_e;

endpackage

`default_nettype wire

// File: src/ram_sdp.sv
////////////////////
// Simple dual-port RAM
// One write port, one registered read port
////////////////////

`default_nettype none

module ram_sdp #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8
) (
  input  wire                   clk,
  input  wire                   wr_en,
  input  wire  [ADDR_WIDTH-1:0] wr_addr,
  input  wire  [DATA_WIDTH-1:0] wr_data,
  input  wire  [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];  // Block RAM array

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, one cycle of latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: src/fifo_register.sv
////////////////////
// FIFO in flip-flops
// Show-ahead head, counted fill level
////////////////////

`default_nettype none

module fifo_register #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 4
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    push,
  input  wire   [DATA_WIDTH-1:0] data_in,
  input  wire                    pop,
  output logic  [DATA_WIDTH-1:0] data_out,
  output logic                   full,
  output logic                   empty,
  output ctrl_pkg::level_t       fill_level
);

  import ctrl_pkg::*;

  localparam level_t DEPTH = level_t'(2**ADDR_WIDTH);  // Number of entries

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];  // Storage, no reset
  logic [ADDR_WIDTH-1:0] wr_ptr;               // Next slot to write
  logic [ADDR_WIDTH-1:0] rd_ptr;               // Current head

  assign data_out = mem[rd_ptr];    // Show-ahead
  assign full     = (fill_level == DEPTH);
  assign empty    = (fill_level == '0);

  // Storage write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_in;
    end
  end

  ////////////////////
  // Pointers and level
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_level <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Level moves only when one side is active
      if (push && !pop) begin
        fill_level <= fill_level + 1'b1;
      end else if (pop && !push) begin
        fill_level <= fill_level - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
////////////////////
// Synchronous FIFO wrapper
// Register or RAM storage, status values
////////////////////

`default_nettype none

module sync_fifo #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      push,
  input  wire stream_pkg::sample_t push_data,
  input  wire                      pop,
  input  wire ctrl_pkg::level_t    almost_full_level,
  output stream_pkg::sample_t      head,
  output logic                     empty,
  output ctrl_pkg::status_t        status
);

  import ctrl_pkg::*;

  // Small memories stay in flops, large ones go to block RAM
  localparam bit USE_REGS = (DATA_WIDTH * 2**ADDR_WIDTH) <= 2048;

  localparam level_t DEPTH = level_t'(2**ADDR_WIDTH);

  logic   wr_en;       // Accepted push
  logic   full;
  level_t fill_level;  // Words held, both paths
  level_t max_level;
  logic   overflow;

  // Full FIFO still takes a word when one leaves in the same cycle
  assign wr_en = push && (!full || pop);

  generate
    if (USE_REGS) begin : g_regs

      fifo_register #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
      ) fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (wr_en),
        .data_in    (push_data),
        .pop        (pop),
        .data_out   (head),
        .full       (full),
        .empty      (empty),
        .fill_level (fill_level)
      );

    end else begin : g_ram

      localparam int STAGE_ADDR_WIDTH = 1;  // Output stage of two words

      logic [ADDR_WIDTH:0]   wr_ptr;       // Extra bit tells full from empty
      logic [ADDR_WIDTH:0]   rd_ptr;
      logic [ADDR_WIDTH:0]   ram_level;    // Words still in the RAM
      logic [DATA_WIDTH-1:0] ram_rd_data;
      logic                  ram_rd;       // Move one word to the stage
      logic                  stage_wr;     // RAM word lands in the stage
      level_t                stage_level;
      logic                  stage_room;

      assign ram_level = wr_ptr - rd_ptr;
      // Count the word in flight so the stage never overfills
      assign stage_room = (stage_level + level_t'(stage_wr)) <= (level_t'(1) + level_t'(pop));
      assign ram_rd     = (ram_level != '0) && stage_room;
      assign full       = (fill_level == DEPTH);

      ////////////////////
      // RAM pointers and refill
      ////////////////////

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          wr_ptr   <= '0;
          rd_ptr   <= '0;
          stage_wr <= 1'b0;
        end else begin
          if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
          end
          if (ram_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
          end
          stage_wr <= ram_rd;  // Matches the RAM read latency
        end
      end

      // Overall level, counted on ingress and egress
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          fill_level <= '0;
        end else if (wr_en && !pop) begin
          fill_level <= fill_level + 1'b1;
        end else if (pop && !wr_en) begin
          fill_level <= fill_level - 1'b1;
        end
      end

      ram_sdp #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
      ) ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_ptr[ADDR_WIDTH-1:0]),
        .wr_data (push_data),
        .rd_addr (rd_ptr[ADDR_WIDTH-1:0]),
        .rd_data (ram_rd_data)
      );

      // Hides the RAM read latency, keeps the head show-ahead
      fifo_register #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (STAGE_ADDR_WIDTH)
      ) stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (stage_wr),
        .data_in    (ram_rd_data),
        .pop        (pop),
        .data_out   (head),
        .full       (),
        .empty      (empty),
        .fill_level (stage_level)
      );

    end
  endgenerate

  ////////////////////
  // Status
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      max_level <= '0;
      overflow  <= 1'b0;
    end else begin
      if (fill_level > max_level) begin
        max_level <= fill_level;
      end
      if (push && !wr_en) begin
        overflow <= 1'b1;  // Dropped sample, held until reset
      end
    end
  end

  assign status.fill_level     = fill_level;
  assign status.max_fill_level = max_level;
  assign status.almost_full    = (fill_level >= almost_full_level);
  assign status.full           = full;
  assign status.overflow       = overflow;

endmodule

`default_nettype wire

// File: src/flush_timer.sv
////////////////////
// Flush timer
// Counts idle cycles of a waiting partial burst
////////////////////

`default_nettype none

module flush_timer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     run,
  input  wire ctrl_pkg::timeout_t timeout,
  output logic                    expired
);

  import ctrl_pkg::*;

  timeout_t count;  // Cycles since run rose

  // Saturating count, cleared whenever run drops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!run) begin
      count <= '0;
    end else if (count < timeout) begin
      count <= count + 1'b1;
    end
  end

  // Held while run stays high
  assign expired = run && (count >= timeout);

endmodule

`default_nettype wire

// File: src/burst_ctrl.sv
////////////////////
// Burst controller
// Pops the FIFO and frames the egress beats
////////////////////

`default_nettype none

module burst_ctrl (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire ctrl_pkg::level_t    fill_level,
  input  wire                      empty,
  input  wire stream_pkg::sample_t head,
  input  wire ctrl_pkg::level_t    burst_len,
  input  wire                      expired,
  output logic                     pop,
  output logic                     timer_run,
  output logic                     out_valid,
  output stream_pkg::beat_t        out_beat
);

  import ctrl_pkg::*;

  burst_state_e state_q;
  level_t       remain_q;    // Words left in this burst
  logic         first_q;     // Next pop is the first of the burst
  logic         trigger;     // Start a burst
  level_t       burst_size;  // Size latched on trigger

  // Full burst ready, or partial burst waited too long
  assign trigger    = (fill_level != '0) && ((fill_level >= burst_len) || expired);
  assign burst_size = (fill_level < burst_len) ? fill_level : burst_len;
  assign timer_run  = (state_q == IDLE) && (fill_level != '0);
  assign pop        = (state_q == BURST) && !empty;  // Gaps while the head refills

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      remain_q  <= '0;
      first_q   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop;  // Beat follows its pop by one cycle
      case (state_q)
        IDLE: begin
          if (trigger) begin
            remain_q <= burst_size;
            first_q  <= 1'b1;
            state_q  <= BURST;
          end
        end
        BURST: begin
          if (pop) begin
            remain_q <= remain_q - 1'b1;
            first_q  <= 1'b0;
            if (remain_q == level_t'(1)) begin
              state_q <= IDLE;  // Last word popped
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Beat payload and frame markers
  always_ff @(posedge clk) begin
    if (pop) begin
      out_beat.sof  <= first_q;
      out_beat.eof  <= (remain_q == level_t'(1));
      out_beat.data <= head;
    end
  end

endmodule

`default_nettype wire

// File: src/burst_packer_top.sv
////////////////////
// Burst packer top level
// FIFO, flush timer and burst controller
////////////////////

`default_nettype none

module burst_packer_top #(
  parameter int DATA_WIDTH = $bits(stream_pkg::sample_t),
  parameter int ADDR_WIDTH = 8  // Depth 256, RAM storage
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      in_valid,
  input  wire stream_pkg::sample_t in_data,
  input  wire ctrl_pkg::cfg_t      cfg,
  output logic                     out_valid,
  output stream_pkg::beat_t        out_beat,
  output ctrl_pkg::status_t        status
);

  import stream_pkg::*;
  import ctrl_pkg::*;

  sample_t head;       // FIFO head word
  logic    empty;
  logic    pop;
  logic    timer_run;
  logic    expired;

  ////////////////////
  // Ingress buffer
  ////////////////////

  sync_fifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) fifo_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .push              (in_valid),  // No back-pressure on ingress
    .push_data         (in_data),
    .pop               (pop),
    .almost_full_level (cfg.almost_full_level),
    .head              (head),
    .empty             (empty),
    .status            (status)
  );

  // Partial burst timeout
  flush_timer timer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (timer_run),
    .timeout (cfg.flush_timeout),
    .expired (expired)
  );

  burst_ctrl ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fill_level (status.fill_level),
    .empty      (empty),
    .head       (head),
    .burst_len  (cfg.burst_len),
    .expired    (expired),
    .pop        (pop),
    .timer_run  (timer_run),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
  );

endmodule

`default_nettype wire

// File: verification/burst_packer_tb.sv
////////////////////
// Testbench for the burst packer driven by the vector file
// Queue model of samples and frame sizes plus status checks
////////////////////

`default_nettype none

module burst_packer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import stream_pkg::*;
  import ctrl_pkg::*;

  localparam int ADDR_WIDTH = 8;
  localparam int DEPTH      = 2**ADDR_WIDTH;  // Model capacity

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  sample_t in_data;
  cfg_t    cfg;
  logic    out_valid;
  beat_t   out_beat;
  status_t status;

  sample_t pending[$];    // Accepted samples not yet seen on egress
  int      frames[$];     // Expected burst sizes in order
  int      beat_idx;      // Position inside the current frame
  string   cur_test;
  integer  seed = 85;
  int      budget_cycles;
  bit      budget_ready;  // Watchdog armed once the file is read

  // Vector file contents
  string   names[$];
  string   cmds[$];
  int      arg_a[$];
  int      arg_b[$];
  int      arg_c[$];

  burst_packer_top #(
    .DATA_WIDTH ($bits(sample_t)),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .cfg       (cfg),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .status    (status)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input string what,
                             input longint expected, input longint actual);
    if (expected != actual) begin
      abort_run($sformatf("Mismatch in test %s: %s expected 0x%0h, actual 0x%0h",
                          test, what, expected, actual));
    end
  endtask

  // Reset low for 3 clock cycles
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;  // Release on a falling edge
  endtask

  task automatic reset_and_check();
    check_value(cur_test, "samples left in model", 0, pending.size());
    check_value(cur_test, "frames left in model", 0, frames.size());
    apply_reset();
    check_value(cur_test, "out_valid after reset", 0, out_valid);
    check_value(cur_test, "status after reset", 0, status);
  endtask

  // Back to back strobes
  task automatic write_samples(input int count);
    int      i;
    int      accepted;
    int      len;
    sample_t value;
    accepted = 0;
    len      = int'(cfg.burst_len);
    for (i = 0; i < count; i++) begin
      @(negedge clk);
      value    = sample_t'($random(seed));
      in_valid = 1'b1;
      in_data  = value;
      if (pending.size() < DEPTH) begin  // Model keeps what a 256 deep FIFO accepts
        pending.push_back(value);
        accepted++;
        if (accepted % len == 0) begin
          frames.push_back(len);  // Full burst
        end
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    if (accepted % len != 0) begin
      frames.push_back(accepted % len);  // Partial burst after the timeout
    end
  endtask

  // Negative max skips that field
  task automatic check_status(input int exp_max, input int exp_ovf, input int exp_af);
    repeat (2) @(negedge clk);  // Registered max and overflow settle
    if (exp_max >= 0) begin
      check_value(cur_test, "max_fill_level", exp_max, status.max_fill_level);
    end
    check_value(cur_test, "overflow", exp_ovf, status.overflow);
    check_value(cur_test, "almost_full", exp_af, status.almost_full);
  endtask

  ////////////////////
  // Egress monitor
  ////////////////////

  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (pending.size() == 0 || frames.size() == 0) begin
        abort_run($sformatf("Test %s: a beat came out with no sample waiting", cur_test));
      end else begin
        check_value(cur_test, "beat data", pending[0], out_beat.data);
        check_value(cur_test, "beat sof", beat_idx == 0, out_beat.sof);
        check_value(cur_test, "beat eof", beat_idx == frames[0] - 1, out_beat.eof);
        pending.delete(0);
        if (beat_idx == frames[0] - 1) begin
          frames.delete(0);  // Frame complete
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
    end
  end

  // Watchdog
  initial begin
    wait (budget_ready);
    repeat (budget_cycles) @(posedge clk);
    abort_run($sformatf("Timeout: the vectors did not finish within %0d cycles",
                        budget_cycles));
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int    fd;
    int    code;
    int    i;
    int    a;
    int    b;
    int    c;
    int    work;
    int    max_timeout;
    string line;
    string name;
    string cmd;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    cfg.burst_len         = level_t'(8);
    cfg.almost_full_level = level_t'(200);  // Nonzero keeps almost_full low
    cfg.flush_timeout     = timeout_t'(40);
    beat_idx     = 0;
    cur_test     = "startup";
    work         = 0;
    max_timeout  = 0;
    budget_ready = 1'b0;
    fd = $fopen("verification/burst_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open verification/burst_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      a = 0;
      b = 0;
      c = 0;
      if (code > 0 && line.len() > 0 && line[0] != "#") begin
        code = $sscanf(line, "%s %s %d %d %d", name, cmd, a, b, c);
        if (code >= 2) begin
          names.push_back(name);
          cmds.push_back(cmd);
          arg_a.push_back(a);
          arg_b.push_back(b);
          arg_c.push_back(c);
          work += 1;  // Each line counts one word
          if (cmd == "write" || cmd == "idle") begin
            work += a;
          end
          if (cmd == "cfg" && c > max_timeout) begin
            max_timeout = c;
          end
        end
      end
    end
    $fclose(fd);
    budget_cycles = 20 * work + max_timeout;
    budget_ready  = 1'b1;
    apply_reset();
    for (i = 0; i < cmds.size(); i++) begin
      cur_test = names[i];
      if (cmds[i] == "cfg") begin
        @(negedge clk);
        cfg.burst_len         = level_t'(arg_a[i]);
        cfg.almost_full_level = level_t'(arg_b[i]);
        cfg.flush_timeout     = timeout_t'(arg_c[i]);
      end else if (cmds[i] == "write") begin
        write_samples(arg_a[i]);
      end else if (cmds[i] == "idle") begin
        repeat (arg_a[i]) @(negedge clk);
      end else if (cmds[i] == "expect") begin
        check_status(arg_a[i], arg_b[i], arg_c[i]);
      end else if (cmds[i] == "reset") begin
        reset_and_check();
      end else begin
        abort_run($sformatf("Unknown command %s in the vector file", cmds[i]));
      end
    end
    cur_test = "end of run";
    check_value(cur_test, "samples never emitted", 0, pending.size());
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/burst_vectors.txt
# Columns: test_name command arg1 arg2 arg3
# cfg: burst_len almost_full_level flush_timeout; write/idle: count; expect: max_fill overflow almost_full (max -1 skips)
reset_state    reset   0    0    0
reset_state    cfg     8    200  40
reset_state    idle    30   0    0
reset_state    expect  0    0    0
full_bursts    cfg     8    200  40
full_bursts    write   30   0    0
full_bursts    idle    150  0    0
full_bursts    expect  -1   0    0
full_bursts    reset   0    0    0
timeout_flush  cfg     16   100  30
timeout_flush  write   5    0    0
timeout_flush  idle    80   0    0
timeout_flush  expect  5    0    0
timeout_flush  reset   0    0    0
almost_full    cfg     64   40   200
almost_full    write   50   0    0
almost_full    expect  50   0    1
almost_full    idle    400  0    0
almost_full    expect  50   0    0
almost_full    reset   0    0    0
overflow       cfg     300  200  4000
overflow       write   260  0    0
overflow       expect  256  1    1
overflow       idle    4600 0    0
overflow       expect  256  1    0

// File: vlog.f
src/stream_pkg.sv
src/ctrl_pkg.sv
src/ram_sdp.sv
src/fifo_register.sv
src/sync_fifo.sv
src/flush_timer.sv
src/burst_ctrl.sv
src/burst_packer_top.sv
verification/burst_packer_tb.sv
